/* hdl/sv39_pkg.sv */
// Sv39 architecture constants and page table entry layout shared by the walker RTL and testbench

package sv39_pkg;

    // ----------------------------------------
    // address geometry
    // ----------------------------------------
    localparam int VLEN          = 39;
    localparam int PLEN          = 56;
    localparam int PPN_W         = 44;
    localparam int PAGE_OFFSET_W = 12;
    localparam int VPN_W         = 9;

    // a PTE is 8 bytes, so table pointers have three low zero bits
    localparam int PTE_SIZE_LOG2 = 3;

    // ----------------------------------------
    // page table entry
    // ----------------------------------------
    // field order gives v at bit 0 and g at bit 5
    typedef struct packed {
        logic [9:0]       reserved;
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    // ----------------------------------------
    // walk levels
    // ----------------------------------------
    // LVL1 maps 1 GiB, LVL2 maps 2 MiB, LVL3 maps 4 KiB
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } walk_lvl_e;

endpackage

/* hdl/ptw_port_pkg.sv */
// Port structures of the page table walker: memory bus, TLB miss and update, PTE verdict

package ptw_port_pkg;

    import sv39_pkg::*;

    // ----------------------------------------
    // memory port
    // ----------------------------------------
    // read-only port, the walker never drives we high
    typedef struct packed {
        logic            data_req;
        logic [PLEN-1:0] address;
        logic [7:0]      be;
        logic [1:0]      size;
        logic            we;
    } mem_req_t;

    typedef struct packed {
        logic        data_gnt;
        logic        data_rvalid;
        logic [63:0] data_rdata;
    } mem_rsp_t;

    // ----------------------------------------
    // TLB side
    // ----------------------------------------
    typedef struct packed {
        logic            access;
        logic            hit;
        logic [VLEN-1:0] vaddr;
    } tlb_miss_t;

    // content carries the accumulated global bit
    typedef struct packed {
        logic               valid;
        logic               is_2m;
        logic               is_1g;
        logic [3*VPN_W-1:0] vpn;
        pte_t               content;
    } tlb_update_t;

    // ----------------------------------------
    // checker result
    // ----------------------------------------
    typedef struct packed {
        logic is_leaf;
        logic fault;
        logic misaligned;
    } pte_verdict_t;

endpackage

/* hdl/ptw_miss_arbiter.sv */
// Chooses between an ITLB and a DTLB miss and holds the walk context for the walker FSM

`timescale 1ns/10ps

module ptw_miss_arbiter import sv39_pkg::*; import ptw_port_pkg::*; #(
    parameter int ASID_WIDTH = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  enable_translation_i,
    input  logic                  en_ld_st_translation_i,
    input  logic                  lsu_is_store_i,
    input  logic [ASID_WIDTH-1:0] asid_i,
    input  tlb_miss_t             itlb_miss_i,
    input  tlb_miss_t             dtlb_miss_i,
    input  logic                  ptw_active_i,
    output logic                  start_o,
    output logic [VLEN-1:0]       walk_vaddr_o,
    output logic [ASID_WIDTH-1:0] walk_asid_o,
    output logic                  walk_is_instr_o,
    output logic                  walk_is_store_o,
    output logic                  itlb_miss_o,
    output logic                  dtlb_miss_o
);

    logic                  itlb_req;
    logic                  dtlb_req;
    logic [VLEN-1:0]       vaddr_q;
    logic [ASID_WIDTH-1:0] asid_q;
    logic                  is_instr_q;
    logic                  is_store_q;

    // instruction misses only go when the LSU is not touching the DTLB at all
    assign itlb_req = enable_translation_i & itlb_miss_i.access & ~itlb_miss_i.hit
                      & ~dtlb_miss_i.access;
    assign dtlb_req = en_ld_st_translation_i & dtlb_miss_i.access & ~dtlb_miss_i.hit;

    assign itlb_miss_o = itlb_req & ~ptw_active_i;
    assign dtlb_miss_o = dtlb_req & ~ptw_active_i;
    assign start_o     = itlb_miss_o | dtlb_miss_o;

    // new context shows through in the start cycle so the FSM can build the root pointer
    always_comb begin
        if (start_o) begin
            walk_vaddr_o    = itlb_req ? itlb_miss_i.vaddr : dtlb_miss_i.vaddr;
            walk_asid_o     = asid_i;
            walk_is_instr_o = itlb_req;
            walk_is_store_o = dtlb_req & lsu_is_store_i;
        end else begin
            walk_vaddr_o    = vaddr_q;
            walk_asid_o     = asid_q;
            walk_is_instr_o = is_instr_q;
            walk_is_store_o = is_store_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            is_instr_q <= 1'b0;
            is_store_q <= 1'b0;
        end else if (start_o) begin
            is_instr_q <= itlb_req;
            is_store_q <= dtlb_req & lsu_is_store_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_o) begin
            vaddr_q <= walk_vaddr_o;
            asid_q  <= asid_i;
        end
    end

    // the walker only leaves idle on a start from here
    a_active_after_start : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $rose(ptw_active_i) |-> $past(start_o)
    );

endmodule

/* hdl/ptw_pte_check.sv */
// Classifies the PTE fetched by the walker as next-level pointer, usable leaf or page fault

`timescale 1ns/10ps

module ptw_pte_check import sv39_pkg::*; import ptw_port_pkg::*; (
    input  pte_t         pte_i,
    input  walk_lvl_e    lvl_i,
    input  logic         is_instr_i,
    input  logic         is_store_i,
    input  logic         mxr_i,
    output pte_verdict_t verdict_o
);

    logic pte_invalid;
    logic leaf;
    logic perm_fault;
    logic misaligned;

    // v clear, or the reserved w without r encoding
    assign pte_invalid = !pte_i.v || (!pte_i.r && pte_i.w);

    assign leaf = pte_i.r || pte_i.x;

    // ----------------------------------------
    // leaf permission checks
    // ----------------------------------------
    always_comb begin
        perm_fault = 1'b0;
        // accessed bit is managed by software, so a clear one faults
        if (!pte_i.a) begin
            perm_fault = 1'b1;
        end
        if (is_instr_i) begin
            if (!pte_i.x) begin
                perm_fault = 1'b1;
            end
        end else begin
            // mxr makes execute-only pages readable
            if (!(pte_i.r || (pte_i.x && mxr_i))) begin
                perm_fault = 1'b1;
            end
            if (is_store_i && !(pte_i.w && pte_i.d)) begin
                perm_fault = 1'b1;
            end
        end
    end

    // superpages need the PPN bits below their level to be zero
    always_comb begin
        case (lvl_i)
            LVL1:    misaligned = (pte_i.ppn[2*VPN_W-1:0] != '0);
            LVL2:    misaligned = (pte_i.ppn[VPN_W-1:0] != '0);
            default: misaligned = 1'b0;
        endcase
    end

    // ----------------------------------------
    // verdict
    // ----------------------------------------
    always_comb begin
        verdict_o = '0;
        if (pte_invalid) begin
            verdict_o.fault = 1'b1;
        end else if (!leaf) begin
            // a pointer at the last level has nowhere to go
            verdict_o.fault = (lvl_i == LVL3);
        end else begin
            verdict_o.is_leaf    = 1'b1;
            verdict_o.misaligned = misaligned;
            verdict_o.fault      = perm_fault || misaligned;
        end
    end

endmodule

/* hdl/ptw_walk_fsm.sv */
// Walk state machine: issues PTE reads, tracks level and pointer, pulses TLB updates or errors

`timescale 1ns/10ps

module ptw_walk_fsm import sv39_pkg::*; import ptw_port_pkg::*; #(
    parameter int ASID_WIDTH = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  start_i,
    input  logic [VLEN-1:0]       vaddr_i,
    input  logic [ASID_WIDTH-1:0] asid_i,
    input  logic                  is_instr_i,
    input  logic [PPN_W-1:0]      satp_ppn_i,
    input  mem_rsp_t              mem_rsp_i,
    input  pte_verdict_t          verdict_i,
    output mem_req_t              mem_req_o,
    output pte_t                  pte_o,
    output walk_lvl_e             lvl_o,
    output tlb_update_t           itlb_update_o,
    output tlb_update_t           dtlb_update_o,
    output logic [ASID_WIDTH-1:0] update_asid_o,
    output logic [VLEN-1:0]       update_vaddr_o,
    output logic                  ptw_active_o,
    output logic                  walking_instr_o,
    output logic                  ptw_error_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR
    } state_e;

    state_e          state_q, state_d;
    walk_lvl_e       lvl_q, lvl_d;
    logic [PLEN-1:0] pptr_q, pptr_d;
    logic            global_q, global_d;
    logic            rvalid_q;
    logic [63:0]     rdata_q;
    logic            update_valid;
    logic [VPN_W-1:0] next_vpn;
    tlb_update_t     update_base;

    assign pte_o = pte_t'(rdata_q);
    assign lvl_o = lvl_q;

    assign ptw_active_o    = (state_q != IDLE);
    assign walking_instr_o = is_instr_i;
    assign update_asid_o   = asid_i;
    assign update_vaddr_o  = vaddr_i;

    // ----------------------------------------
    // memory request
    // ----------------------------------------
    always_comb begin
        mem_req_o          = '0;
        mem_req_o.data_req = (state_q == WAIT_GRANT);
        mem_req_o.address  = pptr_q;
        mem_req_o.be       = 8'hFF;
        mem_req_o.size     = 2'b11;
        mem_req_o.we       = 1'b0;
    end

    // VPN field indexing the table one level below the current one
    always_comb begin
        if (lvl_q == LVL1) begin
            next_vpn = vaddr_i[PAGE_OFFSET_W+VPN_W +: VPN_W];
        end else begin
            next_vpn = vaddr_i[PAGE_OFFSET_W +: VPN_W];
        end
    end

    // ----------------------------------------
    // walk control
    // ----------------------------------------
    always_comb begin
        state_d      = state_q;
        lvl_d        = lvl_q;
        pptr_d       = pptr_q;
        global_d     = global_q;
        update_valid = 1'b0;
        ptw_error_o  = 1'b0;

        case (state_q)
            IDLE: begin
                if (start_i) begin
                    lvl_d    = LVL1;
                    global_d = 1'b0;
                    pptr_d   = {satp_ppn_i, vaddr_i[PAGE_OFFSET_W+2*VPN_W +: VPN_W],
                                {PTE_SIZE_LOG2{1'b0}}};
                    state_d  = WAIT_GRANT;
                end
            end
            WAIT_GRANT: begin
                if (mem_rsp_i.data_gnt) begin
                    state_d = PTE_LOOKUP;
                end
            end
            PTE_LOOKUP: begin
                // registered read data is looked at one cycle after rvalid
                if (rvalid_q) begin
                    if (pte_o.g) begin
                        global_d = 1'b1;
                    end
                    if (verdict_i.fault || verdict_i.misaligned) begin
                        state_d = PROPAGATE_ERROR;
                    end else if (verdict_i.is_leaf) begin
                        update_valid = 1'b1;
                        state_d      = IDLE;
                    end else begin
                        lvl_d   = (lvl_q == LVL1) ? LVL2 : LVL3;
                        pptr_d  = {pte_o.ppn, next_vpn, {PTE_SIZE_LOG2{1'b0}}};
                        state_d = WAIT_GRANT;
                    end
                end
            end
            WAIT_RVALID: begin
                if (rvalid_q) begin
                    state_d = IDLE;
                end
            end
            PROPAGATE_ERROR: begin
                ptw_error_o = 1'b1;
                state_d     = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // a read already granted must drain before the walker can start again
        if (flush_i) begin
            update_valid = 1'b0;
            if ((state_q == PTE_LOOKUP && !rvalid_q)
                || (state_q == WAIT_GRANT && mem_rsp_i.data_gnt)) begin
                state_d = WAIT_RVALID;
            end else begin
                state_d = IDLE;
            end
        end
    end

    // ----------------------------------------
    // TLB update
    // ----------------------------------------
    always_comb begin
        update_base           = '0;
        update_base.is_2m     = (lvl_q == LVL2);
        update_base.is_1g     = (lvl_q == LVL1);
        update_base.vpn       = vaddr_i[VLEN-1:PAGE_OFFSET_W];
        update_base.content   = pte_o;
        update_base.content.g = pte_o.g | global_q;
    end

    always_comb begin
        itlb_update_o       = update_base;
        dtlb_update_o       = update_base;
        itlb_update_o.valid = update_valid & is_instr_i;
        dtlb_update_o.valid = update_valid & ~is_instr_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            lvl_q    <= LVL1;
            global_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            lvl_q    <= lvl_d;
            global_q <= global_d;
            rvalid_q <= mem_rsp_i.data_rvalid;
        end
    end

    always_ff @(posedge clk_i) begin
        pptr_q  <= pptr_d;
        rdata_q <= mem_rsp_i.data_rdata;
    end

    // request is held with the same address until the memory grants it
    a_req_held : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o.data_req && !mem_rsp_i.data_gnt && !flush_i)
            |=> (mem_req_o.data_req && $stable(mem_req_o.address))
    );

endmodule

/* hdl/ptw_top.sv */
// Top level of the Sv39 page table walker, connects miss arbiter, walk FSM and PTE checker

`timescale 1ns/10ps

module ptw_top import sv39_pkg::*; import ptw_port_pkg::*; #(
    parameter int ASID_WIDTH = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  enable_translation_i,
    input  logic                  en_ld_st_translation_i,
    input  logic                  lsu_is_store_i,
    input  logic [ASID_WIDTH-1:0] asid_i,
    input  logic [PPN_W-1:0]      satp_ppn_i,
    input  logic                  mxr_i,
    input  tlb_miss_t             itlb_miss_i,
    input  tlb_miss_t             dtlb_miss_i,
    input  mem_rsp_t              mem_rsp_i,
    output mem_req_t              mem_req_o,
    output tlb_update_t           itlb_update_o,
    output tlb_update_t           dtlb_update_o,
    output logic [ASID_WIDTH-1:0] update_asid_o,
    output logic [VLEN-1:0]       update_vaddr_o,
    output logic                  ptw_active_o,
    output logic                  walking_instr_o,
    output logic                  ptw_error_o,
    output logic                  itlb_miss_o,
    output logic                  dtlb_miss_o
);

    // walk context from the arbiter
    logic                  start;
    logic [VLEN-1:0]       walk_vaddr;
    logic [ASID_WIDTH-1:0] walk_asid;
    logic                  walk_is_instr;
    logic                  walk_is_store;

    // FSM to checker and back
    pte_t         pte;
    walk_lvl_e    lvl;
    pte_verdict_t verdict;

    ptw_miss_arbiter #(
        .ASID_WIDTH (ASID_WIDTH)
    ) u_miss_arbiter (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .enable_translation_i   (enable_translation_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .lsu_is_store_i         (lsu_is_store_i),
        .asid_i                 (asid_i),
        .itlb_miss_i            (itlb_miss_i),
        .dtlb_miss_i            (dtlb_miss_i),
        .ptw_active_i           (ptw_active_o),
        .start_o                (start),
        .walk_vaddr_o           (walk_vaddr),
        .walk_asid_o            (walk_asid),
        .walk_is_instr_o        (walk_is_instr),
        .walk_is_store_o        (walk_is_store),
        .itlb_miss_o            (itlb_miss_o),
        .dtlb_miss_o            (dtlb_miss_o)
    );

    ptw_walk_fsm #(
        .ASID_WIDTH (ASID_WIDTH)
    ) u_walk_fsm (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .start_i         (start),
        .vaddr_i         (walk_vaddr),
        .asid_i          (walk_asid),
        .is_instr_i      (walk_is_instr),
        .satp_ppn_i      (satp_ppn_i),
        .mem_rsp_i       (mem_rsp_i),
        .verdict_i       (verdict),
        .mem_req_o       (mem_req_o),
        .pte_o           (pte),
        .lvl_o           (lvl),
        .itlb_update_o   (itlb_update_o),
        .dtlb_update_o   (dtlb_update_o),
        .update_asid_o   (update_asid_o),
        .update_vaddr_o  (update_vaddr_o),
        .ptw_active_o    (ptw_active_o),
        .walking_instr_o (walking_instr_o),
        .ptw_error_o     (ptw_error_o)
    );

    ptw_pte_check u_pte_check (
        .pte_i      (pte),
        .lvl_i      (lvl),
        .is_instr_i (walk_is_instr),
        .is_store_i (walk_is_store),
        .mxr_i      (mxr_i),
        .verdict_o  (verdict)
    );

endmodule

/* sim/tb_clk_gen.sv */
// Testbench clock and reset source, instantiated by the walker testbench top

`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release a little after the edge, like every other testbench input
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2;
        rst_no = 1'b1;
    end

endmodule

/* sim/tb_ptw_top.sv */
// Testbench for the Sv39 walker: reads tables and requests from the data file and checks results

`timescale 1ns/10ps

module tb_ptw_top import sv39_pkg::*; import ptw_port_pkg::*; ();

    localparam int TD_DEPTH = 512;

    logic             clk;
    logic             rst_n;
    logic             flush;
    logic             lsu_is_store;
    logic [15:0]      asid;
    logic [PPN_W-1:0] satp_ppn;
    logic             mxr;
    tlb_miss_t        itlb_miss_in;
    tlb_miss_t        dtlb_miss_in;
    mem_rsp_t         mem_rsp;
    mem_req_t         mem_req;
    tlb_update_t      itlb_update;
    tlb_update_t      dtlb_update;
    logic [15:0]      update_asid;
    logic [VLEN-1:0]  update_vaddr;
    logic             ptw_active;
    logic             walking_instr;
    logic             ptw_error;
    logic             itlb_miss;
    logic             dtlb_miss;

    logic [63:0]      td [TD_DEPTH];
    logic [63:0]      page_mem [logic [PLEN-1:0]];
    logic [31:0]      rng_state = 32'd49872;
    logic             hold_grant;
    bit               parsed;
    int               req_total;
    int               error_count;

    tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) u_clk_gen (.clk_o(clk), .rst_no(rst_n));

    ptw_top #(.ASID_WIDTH(16)) dut (
        .clk_i(clk), .rst_ni(rst_n), .flush_i(flush),
        .enable_translation_i(1'b1), .en_ld_st_translation_i(1'b1),
        .lsu_is_store_i(lsu_is_store), .asid_i(asid), .satp_ppn_i(satp_ppn), .mxr_i(mxr),
        .itlb_miss_i(itlb_miss_in), .dtlb_miss_i(dtlb_miss_in), .mem_rsp_i(mem_rsp),
        .mem_req_o(mem_req), .itlb_update_o(itlb_update), .dtlb_update_o(dtlb_update),
        .update_asid_o(update_asid), .update_vaddr_o(update_vaddr),
        .ptw_active_o(ptw_active), .walking_instr_o(walking_instr),
        .ptw_error_o(ptw_error), .itlb_miss_o(itlb_miss), .dtlb_miss_o(dtlb_miss)
    );

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [63:0] read_mem(input logic [PLEN-1:0] addr);
        if (page_mem.exists(addr)) begin
            return page_mem[addr];
        end
        return 64'h0;
    endfunction

    // size code 0 is 4 KiB, 1 is 2 MiB, 2 is 1 GiB
    function automatic tlb_update_t expected_update(input logic [VLEN-1:0] va,
                                                    input logic [1:0] size,
                                                    input logic [PPN_W-1:0] ppn,
                                                    input logic g);
        tlb_update_t upd;
        upd             = '0;
        upd.valid       = 1'b1;
        upd.is_2m       = (size == 2'd1);
        upd.is_1g       = (size == 2'd2);
        upd.vpn         = va[VLEN-1:PAGE_OFFSET_W];
        upd.content.ppn = ppn;
        upd.content.g   = g;
        return upd;
    endfunction

    task automatic stop_run();
        error_count++;
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_update(input string name, input tlb_update_t act,
                                input tlb_update_t exp);
        logic bad;
        bad = (act.valid !== exp.valid);
        if (exp.valid) begin
            bad = bad || (act.is_2m !== exp.is_2m) || (act.is_1g !== exp.is_1g)
                  || (act.vpn !== exp.vpn) || (act.content.ppn !== exp.content.ppn)
                  || (act.content.g !== exp.content.g);
        end
        if (bad) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
            stop_run();
        end
    endtask

    task automatic check_error(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, act, exp);
            stop_run();
        end
    endtask

    task automatic check_miss(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, act, exp);
            stop_run();
        end
    endtask

    // context that travels with the update or error of the running walk
    task automatic check_context(input logic [VLEN-1:0] vaddr_exp, input logic [15:0] asid_exp,
                                 input logic instr_exp);
        if (update_vaddr !== vaddr_exp) begin
            $display("** Error at %0t: update_vaddr_o = %h, expected %h",
                     $time, update_vaddr, vaddr_exp);
            stop_run();
        end
        if (update_asid !== asid_exp) begin
            $display("** Error at %0t: update_asid_o = %h, expected %h",
                     $time, update_asid, asid_exp);
            stop_run();
        end
        if (walking_instr !== instr_exp) begin
            $display("** Error at %0t: walking_instr_o = %b, expected %b",
                     $time, walking_instr, instr_exp);
            stop_run();
        end
    endtask

    // ----------------------------------------
    // memory responder
    // ----------------------------------------
    // grant after 0 to 3 cycles, read data one cycle after the grant
    initial begin
        logic            gnt_prev;
        logic [PLEN-1:0] gnt_addr;
        logic [31:0]     delay;
        logic            delay_set;
        mem_rsp   = '0;
        gnt_prev  = 1'b0;
        gnt_addr  = '0;
        delay     = '0;
        delay_set = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            mem_rsp.data_rvalid = gnt_prev;
            mem_rsp.data_rdata  = gnt_prev ? read_mem(gnt_addr) : 64'h0;
            mem_rsp.data_gnt    = 1'b0;
            gnt_prev            = 1'b0;
            if (mem_req.data_req && !hold_grant) begin
                if (!delay_set) begin
                    rng_state = xorshift(rng_state);
                    delay     = rng_state % 4;
                    delay_set = 1'b1;
                end
                if (delay == 0) begin
                    mem_rsp.data_gnt = 1'b1;
                    gnt_addr         = mem_req.address;
                    gnt_prev         = 1'b1;
                    delay_set        = 1'b0;
                end else begin
                    delay = delay - 1;
                end
            end else begin
                delay_set = 1'b0;
            end
        end
    end

    // 60 cycles per request
    initial begin
        wait (parsed);
        repeat (req_total * 60 + 20) @(posedge clk);
        $display("timeout: the walker did not finish all requests in time");
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    // ----------------------------------------
    // request sequences
    // ----------------------------------------
    task automatic wait_result();
        @(posedge clk);
        #1;
        while (!(itlb_update.valid || dtlb_update.valid || ptw_error)) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_idle();
        @(posedge clk);
        #1;
        while (ptw_active) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_outcome(input logic is_instr, input logic [63:0] kind,
                                 input tlb_update_t exp);
        if (kind == 64'd0) begin
            check_error("ptw_error_o", ptw_error, 1'b0);
            check_update("itlb_update_o", itlb_update, is_instr ? exp : '0);
            check_update("dtlb_update_o", dtlb_update, is_instr ? '0 : exp);
        end else begin
            check_error("ptw_error_o", ptw_error, 1'b1);
            check_update("itlb_update_o", itlb_update, '0);
            check_update("dtlb_update_o", dtlb_update, '0);
        end
    endtask

    // words: tag src vaddr store mxr satp kind size ppn g
    task automatic run_request(input int i);
        logic [1:0]      src;
        logic [VLEN-1:0] va;
        logic [15:0]     req_asid;
        tlb_update_t     exp;
        src      = td[i+1][1:0];
        va       = td[i+2][VLEN-1:0];
        req_asid = 16'h0100 + 16'(i);
        exp      = expected_update(va, td[i+7][1:0], td[i+8][PPN_W-1:0], td[i+9][0]);
        @(posedge clk);
        #2;
        lsu_is_store = td[i+3][0];
        mxr          = td[i+4][0];
        satp_ppn     = td[i+5][PPN_W-1:0];
        asid         = req_asid;
        hold_grant   = (src == 2'd3);
        itlb_miss_in = '{access: (src == 2'd1 || src == 2'd2), hit: 1'b0, vaddr: va};
        dtlb_miss_in = '{access: (src != 2'd1), hit: 1'b0, vaddr: va};
        #1;
        check_miss("itlb_miss_o", itlb_miss, src == 2'd1);
        check_miss("dtlb_miss_o", dtlb_miss, src != 2'd1);
        @(posedge clk);
        #2;
        // inputs move away so the walk has to run on the captured context
        dtlb_miss_in.access = 1'b0;
        dtlb_miss_in.vaddr  = ~va;
        if (src != 2'd2) begin
            itlb_miss_in.access = 1'b0;
            itlb_miss_in.vaddr  = ~va;
            asid                = ~req_asid;
        end
        if (src == 2'd3) begin
            // flush while the request is stuck waiting for its grant
            @(posedge clk);
            #1;
            while (!mem_req.data_req) begin
                @(posedge clk);
                #1;
            end
            #1;
            flush = 1'b1;
            @(posedge clk);
            #2;
            flush      = 1'b0;
            hold_grant = 1'b0;
            #1;
            if (ptw_active) begin
                $display("walker still active after a flush in the grant wait");
                stop_run();
            end
            repeat (4) begin
                @(posedge clk);
                #1;
                check_update("itlb_update_o", itlb_update, '0);
                check_update("dtlb_update_o", dtlb_update, '0);
                check_error("ptw_error_o", ptw_error, 1'b0);
            end
        end else begin
            wait_result();
            check_outcome(src == 2'd1, td[i+6], exp);
            check_context(va, req_asid, src == 2'd1);
            wait_idle();
            if (src == 2'd2) begin
                // instruction miss goes once the data side is quiet
                check_miss("itlb_miss_o", itlb_miss, 1'b1);
                @(posedge clk);
                #2;
                itlb_miss_in.access = 1'b0;
                itlb_miss_in.vaddr  = ~va;
                asid                = ~req_asid;
                wait_result();
                check_outcome(1'b1, td[i+6], exp);
                check_context(va, req_asid, 1'b1);
                wait_idle();
            end
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int idx;
        flush        = 1'b0;
        lsu_is_store = 1'b0;
        asid         = 16'h0012;
        satp_ppn     = '0;
        mxr          = 1'b0;
        itlb_miss_in = '0;
        dtlb_miss_in = '0;
        hold_grant   = 1'b0;
        error_count  = 0;
        req_total    = 0;
        for (int k = 0; k < TD_DEPTH; k++) begin
            td[k] = 64'h0;
        end
        $readmemh("sim/ptw_testdata.txt", td);

        // first pass loads the page tables and counts requests
        idx = 0;
        while (idx < TD_DEPTH && td[idx] != 64'd0) begin
            if (td[idx] == 64'd1) begin
                page_mem[td[idx+1][PLEN-1:0]] = td[idx+2];
                idx += 3;
            end else if (td[idx] == 64'd2) begin
                req_total++;
                idx += 10;
            end else begin
                $display("unknown record type in the data file at word %0d", idx);
                stop_run();
            end
        end
        parsed = 1'b1;

        @(posedge rst_n);
        idx = 0;
        while (idx < TD_DEPTH && td[idx] != 64'd0) begin
            if (td[idx] == 64'd1) begin
                idx += 3;
            end else begin
                run_request(idx);
                idx += 10;
            end
        end

        if (error_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

endmodule

/* ptw_top.f */
hdl/sv39_pkg.sv
hdl/ptw_port_pkg.sv
hdl/ptw_miss_arbiter.sv
hdl/ptw_pte_check.sv
hdl/ptw_walk_fsm.sv
hdl/ptw_top.sv
sim/tb_clk_gen.sv
sim/tb_ptw_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the page table walker testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_ptw_top -f ptw_top.f -o vsim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/vsim 2>&1 | tee "$LOG"

grep -q "Simulation finished: FAIL" "$LOG" && { echo "run failed"; exit 1; }
grep -q "Simulation finished: PASS" "$LOG" || { echo "run ended without result"; exit 1; }
exit 0

/* sim/ptw_testdata.txt */
// memory: 1 <phys addr> <pte>, all hex
// request: 2 <src 0=D 1=I 2=I+D 3=D+flush> <vaddr> <store> <mxr> <satp ppn> <kind 0=update 1=error 2=none> <size 0=4K 1=2M 2=1G> <ppn> <g>
1 80000008 20000401
1 80000010 20000C21
1 80000018 10000043
1 80000020 10080043
1 80001010 20000801
1 80001020 80043
1 80001028 80443
1 80002018 48D14C7
1 80002028 CCC47
1 80002030 111049
1 80002038 15544B
1 80003000 20001001
1 80004000 2AF043
2 0 40403000 1 0 80000 0 0 12345 0
2 0 40800000 0 0 80000 0 1 200 0
2 0 40A00000 0 0 80000 1 0 0 0
2 0 C0000000 0 0 80000 0 2 40000 0
2 0 100000000 0 0 80000 1 0 0 0
2 1 40403000 0 0 80000 1 0 0 0
2 0 40405000 1 0 80000 1 0 0 0
2 0 40406000 0 1 80000 0 0 444 0
2 1 40406000 0 0 80000 0 0 444 0
2 0 80000000 0 0 80000 0 0 ABC 1
2 0 80001000 0 0 80000 1 0 0 0
2 0 140000000 0 0 80000 1 0 0 0
2 2 40407000 0 0 80000 0 0 555 0
2 3 40403000 0 0 80000 2 0 0 0
2 0 40403000 0 0 80000 0 0 12345 0
0
